// ==== circular_queue.sv ====
`timescale 1ns/1ps

module circular_queue #(
    parameter type QUEUE_TYPE = rv32i_types::instruction_info_reg_t,
    parameter int DEPTH = 8,
    parameter int SS = rv32i_types::SS,
    parameter rv32i_types::queue_init_e INIT_TYPE = rv32i_types::EMPTY
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [1:0]                     push_count,
    input  QUEUE_TYPE                      in [SS],
    input  logic [1:0]                     pop_count,
    output QUEUE_TYPE                      out [SS],
    output logic [$clog2(DEPTH+1)-1:0]     count,
    output logic                           full,
    output logic                           empty
);
    import rv32i_types::*;

    // Pointers wrap naturally, DEPTH is a power of two
    localparam int PW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);
    localparam int W  = $bits(QUEUE_TYPE);

    QUEUE_TYPE       mem [DEPTH];
    logic [PW-1:0]   head;
    logic [PW-1:0]   tail;

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head <= '0;
            tail <= '0;
            // Free list starts full, tail wrapped onto head
            count <= (INIT_TYPE == FREE_LIST) ? CW'(DEPTH) : '0;
        end else begin
            head  <= head + PW'(pop_count);
            tail  <= tail + PW'(push_count);
            count <= count + CW'(push_count) - CW'(pop_count);
        end
    end

    // Storage, preloaded with the spare physical registers
    always_ff @(posedge clk) begin
        if (!rst_n && INIT_TYPE == FREE_LIST) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= QUEUE_TYPE'(W'(NUM_ARCH_REGS + i));
            end
        end else begin
            // Up to SS entries written from the tail
            for (int s = 0; s < SS; s++) begin
                if (s < push_count) begin
                    mem[PW'(int'(tail) + s)] <= in[s];
                end
            end
        end
    end

    // Head and the entries behind it
    always_comb begin
        for (int s = 0; s < SS; s++) begin
            out[s] = mem[PW'(int'(head) + s)];
        end
    end

    // Full means no room for a whole group
    assign full  = (DEPTH - int'(count)) < SS;
    assign empty = (count == '0);

    // Producer must respect free space
    push_space_a: assert property (@(posedge clk) disable iff (!rst_n)
        int'(push_count) <= DEPTH - int'(count));

    // Consumer never reads past the occupied entries
    pop_count_a: assert property (@(posedge clk) disable iff (!rst_n)
        int'(pop_count) <= int'(count));

endmodule

// ==== cpu_frontend.sv ====
`timescale 1ns/1ps

module cpu_frontend #(
    parameter int SS = rv32i_types::SS,
    parameter int IQ_DEPTH = 8,
    parameter int FL_DEPTH = 32
) (
    input  logic                               clk,
    input  logic                               rst_n,
    output logic [31:0]                        imem_addr,
    input  logic [31:0]                        imem_rdata,
    input  logic                               imem_resp,
    input  logic                               dispatch_stall,
    input  logic                               retire_valid,
    input  rv32i_types::phys_reg_t             retire_preg,
    output logic                               dispatch_valid,
    output rv32i_types::dispatch_reservation_t dispatch_out [SS]
);
    import rv32i_types::*;

    // Fetch and decode
    logic [31:0]           fetch_pc;
    logic                  fetch_valid;
    instruction_info_reg_t decoded_inst;

    // Pairing and instruction queue
    instruction_info_reg_t pair [SS];
    logic                  pair_push;
    instruction_info_reg_t iq_head [SS];
    logic                  iq_full;
    logic                  iq_empty;

    // Free list
    phys_reg_t                    fl_in [SS];
    phys_reg_t                    fl_regs [SS];
    logic [$clog2(FL_DEPTH+1)-1:0] fl_count;

    // Rename side
    logic       pop_inst_q;
    logic [1:0] pop_free_list;
    arch_reg_t  isa_rs1 [SS];
    arch_reg_t  isa_rs2 [SS];
    arch_reg_t  isa_rd [SS];
    phys_reg_t  rat_rs1 [SS];
    phys_reg_t  rat_rs2 [SS];
    phys_reg_t  rat_rd [SS];
    logic [SS-1:0] regf_we;
    phys_reg_t  rat_dest [SS];

    // Full queue freezes the PC
    fetch_stage fetch_stage_i (
        .clk(clk),
        .rst_n(rst_n),
        .stall(iq_full),
        .imem_resp(imem_resp),
        .imem_addr(imem_addr),
        .fetch_pc(fetch_pc),
        .fetch_valid(fetch_valid)
    );

    id_stage id_stage_i (
        .fetch_pc(fetch_pc),
        .imem_rdata(imem_rdata),
        .instruction_info(decoded_inst)
    );

    two_inst_buff #(.SS(SS)) two_inst_buff_i (
        .clk(clk),
        .rst_n(rst_n),
        .valid(fetch_valid),
        .decoded_inst(decoded_inst),
        .valid_inst(pair),
        .valid_out(pair_push)
    );

    // Whole pairs in and out
    circular_queue #(
        .QUEUE_TYPE(instruction_info_reg_t),
        .DEPTH(IQ_DEPTH),
        .SS(SS),
        .INIT_TYPE(EMPTY)
    ) instruction_queue_i (
        .clk(clk),
        .rst_n(rst_n),
        .push_count(pair_push ? 2'(SS) : 2'd0),
        .in(pair),
        .pop_count(pop_inst_q ? 2'(SS) : 2'd0),
        .out(iq_head),
        .count(),
        .full(iq_full),
        .empty(iq_empty)
    );

    // Retire returns one register per cycle
    assign fl_in = '{default: retire_preg};

    circular_queue #(
        .QUEUE_TYPE(phys_reg_t),
        .DEPTH(FL_DEPTH),
        .SS(SS),
        .INIT_TYPE(FREE_LIST)
    ) free_list_i (
        .clk(clk),
        .rst_n(rst_n),
        .push_count({1'b0, retire_valid}),
        .in(fl_in),
        .pop_count(pop_free_list),
        .out(fl_regs),
        .count(fl_count),
        .full(),
        .empty()
    );

    rat #(.SS(SS)) rat_i (
        .clk(clk),
        .rst_n(rst_n),
        .isa_rs1(isa_rs1),
        .isa_rs2(isa_rs2),
        .isa_rd(isa_rd),
        .rat_rs1(rat_rs1),
        .rat_rs2(rat_rs2),
        .rat_rd(rat_rd),
        .regf_we(regf_we),
        .rat_dest(rat_dest)
    );

    rename_dispatch #(.SS(SS)) rename_dispatch_i (
        .clk(clk),
        .rst_n(rst_n),
        .instruction(iq_head),
        .inst_q_empty(iq_empty),
        .free_list_regs(fl_regs),
        .free_count(fl_count),
        .dispatch_stall(dispatch_stall),
        .rat_rs1(rat_rs1),
        .rat_rs2(rat_rs2),
        .rat_rd(rat_rd),
        .isa_rs1(isa_rs1),
        .isa_rs2(isa_rs2),
        .isa_rd(isa_rd),
        .regf_we(regf_we),
        .rat_dest(rat_dest),
        .pop_inst_q(pop_inst_q),
        .pop_free_list(pop_free_list),
        .dispatch_valid(dispatch_valid),
        .dispatch_out(dispatch_out)
    );

endmodule

// ==== fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,
    input  logic        imem_resp,
    output logic [31:0] imem_addr,
    output logic [31:0] fetch_pc,
    output logic        fetch_valid
);

    logic [31:0] pc;

    // Word taken only while the queue has room
    assign fetch_valid = imem_resp && !stall;

    // Sequential fetch with branches assumed not taken
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= 32'h0;
        end else if (fetch_valid) begin
            pc <= pc + 32'd4;
        end
    end

    // Memory answers in the same cycle
    assign imem_addr = pc;
    assign fetch_pc  = pc;

endmodule

// ==== files.f ====
rv32i_types.sv
circular_queue.sv
fetch_stage.sv
id_stage.sv
two_inst_buff.sv
rat.sv
rename_dispatch.sv
cpu_frontend.sv
tb_cpu_frontend.sv

// ==== id_stage.sv ====
`timescale 1ns/1ps

module id_stage (
    input  logic [31:0]                       fetch_pc,
    input  logic [31:0]                       imem_rdata,
    output rv32i_types::instruction_info_reg_t instruction_info
);
    import rv32i_types::*;

    logic [6:0] opcode;
    arch_reg_t  rs1;
    arch_reg_t  rs2;
    arch_reg_t  rd;

    // Fixed field positions across all formats
    assign opcode = imem_rdata[6:0];
    assign rd     = imem_rdata[11:7];
    assign rs1    = imem_rdata[19:15];
    assign rs2    = imem_rdata[24:20];

    always_comb begin
        instruction_info        = '0;
        instruction_info.pc     = fetch_pc;
        instruction_info.inst   = imem_rdata;
        instruction_info.opcode = opcode;
        // Unused sources read x0, so they rename to physical 0
        unique case (opcode)
            // U and J formats
            OP_LUI, OP_AUIPC, OP_JAL: begin
                instruction_info.rd = rd;
            end
            // I format
            OP_JALR, OP_LOAD, OP_IMM: begin
                instruction_info.rs1 = rs1;
                instruction_info.rd  = rd;
            end
            // R format
            OP_REG: begin
                instruction_info.rs1 = rs1;
                instruction_info.rs2 = rs2;
                instruction_info.rd  = rd;
            end
            // B and S formats, no destination
            OP_BRANCH, OP_STORE: begin
                instruction_info.rs1 = rs1;
                instruction_info.rs2 = rs2;
            end
            default: begin
                instruction_info.rd = '0;
            end
        endcase
        // x0 writes are dropped
        instruction_info.rd_valid = (instruction_info.rd != '0);
    end

endmodule

// ==== rat.sv ====
`timescale 1ns/1ps

module rat #(
    parameter int SS = rv32i_types::SS
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rv32i_types::arch_reg_t isa_rs1 [SS],
    input  rv32i_types::arch_reg_t isa_rs2 [SS],
    input  rv32i_types::arch_reg_t isa_rd [SS],
    output rv32i_types::phys_reg_t rat_rs1 [SS],
    output rv32i_types::phys_reg_t rat_rs2 [SS],
    output rv32i_types::phys_reg_t rat_rd [SS],
    input  logic [SS-1:0]          regf_we,
    input  rv32i_types::phys_reg_t rat_dest [SS]
);
    import rv32i_types::*;

    // Architectural to physical mapping
    phys_reg_t map [NUM_ARCH_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // Identity, x0 stays on physical 0
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                map[i] <= phys_reg_t'(i);
            end
        end else begin
            // Later slot overrides an earlier one on the same rd
            for (int s = 0; s < SS; s++) begin
                if (regf_we[s]) begin
                    map[isa_rd[s]] <= rat_dest[s];
                end
            end
        end
    end

    // Combinational reads, bypass is done by rename
    always_comb begin
        for (int s = 0; s < SS; s++) begin
            rat_rs1[s] = map[isa_rs1[s]];
            rat_rs2[s] = map[isa_rs2[s]];
            rat_rd[s]  = map[isa_rd[s]];
        end
    end

    // Rename never remaps x0
    for (genvar s = 0; s < SS; s++) begin : g_x0_check
        no_x0_write_a: assert property (@(posedge clk) disable iff (!rst_n)
            regf_we[s] |-> isa_rd[s] != '0);
    end

endmodule

// ==== rename_dispatch.sv ====
`timescale 1ns/1ps

module rename_dispatch #(
    parameter int SS = rv32i_types::SS
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  rv32i_types::instruction_info_reg_t instruction [SS],
    input  logic                               inst_q_empty,
    input  rv32i_types::phys_reg_t             free_list_regs [SS],
    input  logic [$clog2(rv32i_types::NUM_PHYS_REGS - rv32i_types::NUM_ARCH_REGS + 1)-1:0]
                                               free_count,
    input  logic                               dispatch_stall,
    input  rv32i_types::phys_reg_t             rat_rs1 [SS],
    input  rv32i_types::phys_reg_t             rat_rs2 [SS],
    input  rv32i_types::phys_reg_t             rat_rd [SS],
    output rv32i_types::arch_reg_t             isa_rs1 [SS],
    output rv32i_types::arch_reg_t             isa_rs2 [SS],
    output rv32i_types::arch_reg_t             isa_rd [SS],
    output logic [SS-1:0]                      regf_we,
    output rv32i_types::phys_reg_t             rat_dest [SS],
    output logic                               pop_inst_q,
    output logic [1:0]                         pop_free_list,
    output logic                               dispatch_valid,
    output rv32i_types::dispatch_reservation_t dispatch_out [SS]
);
    import rv32i_types::*;

    dispatch_reservation_t renamed [SS];
    // Free registers the head group needs
    logic [1:0]            need;
    logic                  pop;

    always_comb begin
        int alloc;
        alloc = 0;
        need  = '0;
        for (int s = 0; s < SS; s++) begin
            // Alias table lookup addresses
            isa_rs1[s] = instruction[s].rs1;
            isa_rs2[s] = instruction[s].rs2;
            isa_rd[s]  = instruction[s].rd;

            renamed[s]          = '0;
            renamed[s].pc       = instruction[s].pc;
            renamed[s].inst     = instruction[s].inst;
            renamed[s].opcode   = instruction[s].opcode;
            renamed[s].rd_valid = instruction[s].rd_valid;
            renamed[s].prs1     = rat_rs1[s];
            renamed[s].prs2     = rat_rs2[s];

            if (instruction[s].rd_valid) begin
                // Free-list heads handed out in slot order
                renamed[s].prd     = free_list_regs[alloc];
                renamed[s].old_prd = rat_rd[s];
                alloc              = alloc + 1;
                need               = need + 2'd1;
            end

            // Older slots in the group shadow the table, latest wins
            for (int j = 0; j < s; j++) begin
                if (instruction[j].rd_valid) begin
                    if (instruction[j].rd == instruction[s].rs1) begin
                        renamed[s].prs1 = renamed[j].prd;
                    end
                    if (instruction[j].rd == instruction[s].rs2) begin
                        renamed[s].prs2 = renamed[j].prd;
                    end
                    if (instruction[s].rd_valid && instruction[j].rd == instruction[s].rd) begin
                        renamed[s].old_prd = renamed[j].prd;
                    end
                end
            end

            rat_dest[s] = renamed[s].prd;
        end
    end

    // Whole group or nothing
    assign pop = !inst_q_empty && (free_count >= need) && !dispatch_stall;

    assign pop_inst_q    = pop;
    assign pop_free_list = pop ? need : 2'd0;

    always_comb begin
        for (int s = 0; s < SS; s++) begin
            regf_we[s] = pop && instruction[s].rd_valid;
        end
    end

    // Dispatch packet one cycle after the pop
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dispatch_valid <= 1'b0;
        end else begin
            dispatch_valid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            dispatch_out <= renamed;
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_cpu_frontend -f files.f

out=$(./obj_dir/Vtb_cpu_frontend)
echo "$out"

if echo "$out" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1

// ==== rv32i_types.sv ====
package rv32i_types;

    // Pipeline width
    parameter int SS = 2;

    // Register file sizes
    parameter int NUM_ARCH_REGS = 32;
    parameter int NUM_PHYS_REGS = 64;

    typedef logic [$clog2(NUM_ARCH_REGS)-1:0] arch_reg_t;
    typedef logic [$clog2(NUM_PHYS_REGS)-1:0] phys_reg_t;

    // RV32I base opcodes
    parameter logic [6:0] OP_LUI    = 7'b0110111;
    parameter logic [6:0] OP_AUIPC  = 7'b0010111;
    parameter logic [6:0] OP_JAL    = 7'b1101111;
    parameter logic [6:0] OP_JALR   = 7'b1100111;
    parameter logic [6:0] OP_BRANCH = 7'b1100011;
    parameter logic [6:0] OP_LOAD   = 7'b0000011;
    parameter logic [6:0] OP_STORE  = 7'b0100011;
    parameter logic [6:0] OP_IMM    = 7'b0010011;
    parameter logic [6:0] OP_REG    = 7'b0110011;

    // One decoded instruction, architectural names
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic [6:0]  opcode;
        arch_reg_t   rs1;
        arch_reg_t   rs2;
        arch_reg_t   rd;
        // Writes a register other than x0
        logic        rd_valid;
    } instruction_info_reg_t;

    // One renamed instruction on its way to the reservation stations
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic [6:0]  opcode;
        phys_reg_t   prs1;
        phys_reg_t   prs2;
        phys_reg_t   prd;
        // Mapping replaced at rename, freed at retire
        phys_reg_t   old_prd;
        logic        rd_valid;
    } dispatch_reservation_t;

    // Queue contents after reset
    typedef enum logic {
        EMPTY,
        FREE_LIST
    } queue_init_e;

endpackage

// ==== tb_cpu_frontend.sv ====
`timescale 1ns/1ps

module tb_cpu_frontend;
    import rv32i_types::*;

    localparam int PROG_WORDS     = 256;
    localparam int NUM_PAIRS      = PROG_WORDS / SS;
    localparam int TIMEOUT_CYCLES = 40 * PROG_WORDS;
    // Retire hold starts after this many checked instructions
    localparam int HOLD_START     = 64;
    // Cycles the hold lasts once the free list runs dry
    localparam int HOLD_TAIL      = 30;

    logic                  clk;
    logic                  rst_n;
    logic [31:0]           imem_addr;
    logic [31:0]           imem_rdata;
    logic                  imem_resp;
    logic                  dispatch_stall;
    logic                  retire_valid;
    phys_reg_t             retire_preg;
    logic                  dispatch_valid;
    dispatch_reservation_t dispatch_out [SS];

    logic [31:0] program_mem [PROG_WORDS];
    logic [31:0] lcg_state = 32'd61;

    // Reference rename state
    phys_reg_t ref_map [NUM_ARCH_REGS];
    phys_reg_t ref_free [$];
    // Old mappings waiting to be retired
    phys_reg_t retire_fifo [$];

    int pairs_checked = 0;
    int mismatches    = 0;
    int failures      = 0;

    // Retire hold bookkeeping
    logic hold_active = 1'b0;
    logic hold_done   = 1'b0;
    logic exhausted   = 1'b0;
    int   stim_cycle  = 0;
    int   release_at  = 0;
    int   stall_left  = 0;

    cpu_frontend #(
        .SS(SS),
        .IQ_DEPTH(8),
        .FL_DEPTH(32)
    ) cpu_frontend_i (
        .clk(clk),
        .rst_n(rst_n),
        .imem_addr(imem_addr),
        .imem_rdata(imem_rdata),
        .imem_resp(imem_resp),
        .dispatch_stall(dispatch_stall),
        .retire_valid(retire_valid),
        .retire_preg(retire_preg),
        .dispatch_valid(dispatch_valid),
        .dispatch_out(dispatch_out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Combinational memory, wraps past the program end (those pairs go unchecked)
    assign imem_rdata = program_mem[imem_addr[9:2]];

    function automatic logic [15:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        // Upper bits, the low ones repeat too soon
        return lcg_state[31:16];
    endfunction

    function automatic arch_reg_t pick_reg();
        logic [15:0] r;
        r = next_random();
        // x0..x7 half the time so dependences inside a pair are common
        if (r[15]) begin
            return {2'b00, r[2:0]};
        end
        return r[4:0];
    endfunction

    function automatic logic [31:0] make_word();
        logic [15:0] r;
        logic [6:0]  op;
        arch_reg_t   rd;
        arch_reg_t   rs1;
        arch_reg_t   rs2;
        r = next_random();
        case (int'(r) % 9)
            0:       op = OP_LUI;
            1:       op = OP_AUIPC;
            2:       op = OP_JAL;
            3:       op = OP_JALR;
            4:       op = OP_BRANCH;
            5:       op = OP_LOAD;
            6:       op = OP_STORE;
            7:       op = OP_IMM;
            default: op = OP_REG;
        endcase
        rd  = pick_reg();
        rs1 = pick_reg();
        rs2 = pick_reg();
        return {r[15:9], rs2, rs1, r[2:0], rd, op};
    endfunction

    // Reference rename of one instruction, slots taken in program order
    function automatic dispatch_reservation_t rename_one(input int idx);
        dispatch_reservation_t r;
        logic [31:0]           w;
        logic [6:0]            op;
        arch_reg_t             rs1;
        arch_reg_t             rs2;
        arch_reg_t             rd;
        w  = program_mem[idx];
        op = w[6:0];
        // Fields by format, unused sources read x0
        rs1 = (op inside {OP_JALR, OP_LOAD, OP_IMM, OP_REG, OP_BRANCH, OP_STORE})
            ? w[19:15] : '0;
        rs2 = (op inside {OP_REG, OP_BRANCH, OP_STORE}) ? w[24:20] : '0;
        rd  = (op inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_LOAD, OP_IMM, OP_REG})
            ? w[11:7] : '0;
        r          = '0;
        r.pc       = 32'(idx * 4);
        r.inst     = w;
        r.opcode   = op;
        // Map already holds slot 0's update, which is the bypass
        r.prs1     = ref_map[rs1];
        r.prs2     = ref_map[rs2];
        r.rd_valid = (rd != '0);
        if (r.rd_valid) begin
            r.old_prd = ref_map[rd];
            if (ref_free.size() == 0) begin
                $display("destination allocated at pc %h while no register was free", r.pc);
                failures++;
            end else begin
                r.prd = ref_free.pop_front();
            end
            ref_map[rd] = r.prd;
        end
        return r;
    endfunction

    task automatic compare_field(input string field, input int slot,
                                 input logic [31:0] got, input logic [31:0] exp);
        assert (got == exp) else begin
            $display("mismatch dispatch_out[%0d].%s in pair %0d: got %h, expected %h",
                     slot, field, pairs_checked, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_pair();
        dispatch_reservation_t exp;
        for (int s = 0; s < SS; s++) begin
            exp = rename_one(pairs_checked * SS + s);
            compare_field("pc", s, dispatch_out[s].pc, exp.pc);
            compare_field("inst", s, dispatch_out[s].inst, exp.inst);
            compare_field("opcode", s, 32'(dispatch_out[s].opcode), 32'(exp.opcode));
            compare_field("prs1", s, 32'(dispatch_out[s].prs1), 32'(exp.prs1));
            compare_field("prs2", s, 32'(dispatch_out[s].prs2), 32'(exp.prs2));
            compare_field("prd", s, 32'(dispatch_out[s].prd), 32'(exp.prd));
            compare_field("old_prd", s, 32'(dispatch_out[s].old_prd), 32'(exp.old_prd));
            compare_field("rd_valid", s, 32'(dispatch_out[s].rd_valid), 32'(exp.rd_valid));
            // Replaced mapping goes back to the free list later
            if (exp.rd_valid) begin
                retire_fifo.push_back(exp.old_prd);
            end
        end
        pairs_checked++;
    endtask

    // Comparator, outputs are stable at the falling edge
    always @(negedge clk) begin
        if (rst_n && dispatch_valid && pairs_checked < NUM_PAIRS) begin
            check_pair();
        end
    end

    // Stimulus and retire driver
    always @(posedge clk) begin
        logic [15:0] r_resp;
        logic [15:0] r_stall;
        logic [15:0] r_ret;
        if (rst_n) begin
            stim_cycle++;
            r_resp  = next_random();
            r_stall = next_random();
            r_ret   = next_random();
            // Register the DUT takes at this edge
            if (retire_valid) begin
                ref_free.push_back(retire_preg);
            end
            // Withhold retires until the free list runs dry
            if (!hold_done && !hold_active && pairs_checked * SS >= HOLD_START) begin
                hold_active = 1'b1;
            end
            if (hold_active && !exhausted && ref_free.size() < SS) begin
                exhausted  = 1'b1;
                release_at = stim_cycle + HOLD_TAIL;
            end
            if (hold_active && exhausted && stim_cycle >= release_at) begin
                hold_active = 1'b0;
                hold_done   = 1'b1;
            end
            imem_resp <= (int'(r_resp) % 8) != 0;
            // Occasional long stalls fill the instruction queue
            if (stall_left > 0) begin
                dispatch_stall <= 1'b1;
                stall_left--;
            end else if (int'(r_stall) % 32 == 0) begin
                dispatch_stall <= 1'b1;
                stall_left = 12;
            end else begin
                dispatch_stall <= (int'(r_stall) % 4) == 0;
            end
            if (!hold_active && retire_fifo.size() > 0 && (int'(r_ret) % 3) != 0) begin
                retire_valid <= 1'b1;
                retire_preg  <= retire_fifo.pop_front();
            end else begin
                retire_valid <= 1'b0;
            end
        end
    end

    initial begin
        int cycles;
        rst_n          = 1'b0;
        imem_resp      = 1'b0;
        dispatch_stall = 1'b0;
        retire_valid   = 1'b0;
        retire_preg    = '0;
        for (int i = 0; i < PROG_WORDS; i++) begin
            program_mem[i] = make_word();
        end
        // Identity map, spare registers from NUM_ARCH_REGS upward
        for (int i = 0; i < NUM_ARCH_REGS; i++) begin
            ref_map[i] = phys_reg_t'(i);
        end
        for (int i = NUM_ARCH_REGS; i < NUM_PHYS_REGS; i++) begin
            ref_free.push_back(phys_reg_t'(i));
        end
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        assert (!dispatch_valid) else begin
            $display("dispatch_valid was high right after reset");
            failures++;
        end
        cycles = 0;
        while (pairs_checked < NUM_PAIRS && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (pairs_checked < NUM_PAIRS) begin
            $display("timeout after %0d cycles with %0d of %0d pairs dispatched",
                     cycles, pairs_checked, NUM_PAIRS);
            failures++;
        end
        if (!exhausted) begin
            $display("free list never ran low while retires were held");
            failures++;
        end
        $display("%0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== two_inst_buff.sv ====
`timescale 1ns/1ps

module two_inst_buff #(
    parameter int SS = rv32i_types::SS
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               valid,
    input  rv32i_types::instruction_info_reg_t decoded_inst,
    output rv32i_types::instruction_info_reg_t valid_inst [SS],
    output logic                               valid_out
);
    import rv32i_types::*;

    localparam int SW = (SS > 1) ? $clog2(SS) : 1;

    // Lower slots wait here until the group completes
    instruction_info_reg_t held [SS-1];
    logic [SW-1:0]         slot;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot <= '0;
        end else if (valid) begin
            slot <= (int'(slot) == SS - 1) ? '0 : slot + SW'(1);
        end
    end

    always_ff @(posedge clk) begin
        for (int s = 0; s < SS - 1; s++) begin
            if (valid && int'(slot) == s) begin
                held[s] <= decoded_inst;
            end
        end
    end

    // Last slot bypasses the holding register
    always_comb begin
        for (int s = 0; s < SS - 1; s++) begin
            valid_inst[s] = held[s];
        end
        valid_inst[SS-1] = decoded_inst;
    end

    assign valid_out = valid && (int'(slot) == SS - 1);

endmodule
